// File: sim/tap_trace.txt
# C valid data keep last id dest user m_ready mon_ready, one record per clock cycle
# E data keep last id dest user, expected monitor beats in order; S frame_count bad_count
C 0 0000 0 0 0 0 0 1 1
C 0 0000 0 0 0 0 0 1 1
C 1 1111 3 0 1 2 0 1 1
C 1 1112 3 0 1 2 0 0 1
C 1 1112 3 0 1 2 0 1 1
C 1 1113 3 1 1 2 0 1 1
C 0 0000 0 0 0 0 0 1 1
C 0 0000 0 0 0 0 0 1 0
C 0 0000 0 0 0 0 0 1 0
C 1 2221 1 1 3 1 0 1 0
C 0 0000 0 0 0 0 0 1 0
C 1 4441 3 0 4 4 0 1 0
C 1 4442 3 1 4 4 0 1 0
C 0 0000 0 0 0 0 0 1 1
C 0 0000 0 0 0 0 0 1 1
C 0 0000 0 0 0 0 0 1 1
C 1 5551 1 1 5 6 0 1 1
C 0 0000 0 0 0 0 0 1 1
C 1 6601 3 0 6 3 0 1 1
C 1 6602 3 0 6 3 0 1 0
C 1 6603 3 0 6 3 0 1 0
C 1 6604 3 1 6 3 0 1 0
C 0 0000 0 0 0 0 0 1 1
C 0 0000 0 0 0 0 0 1 1
C 0 0000 0 0 0 0 0 1 1
C 1 2201 3 0 2 5 0 1 1
C 1 2202 3 1 2 5 0 0 0
C 1 2202 3 1 2 5 0 0 1
C 1 2202 3 1 2 5 0 0 1
C 1 2202 3 1 2 5 0 1 1
C 0 0000 0 0 0 0 0 1 1
E 1111 3 0 1 2 0
E 1112 3 0 1 2 0
E 1113 3 1 1 2 0
E 2221 1 1 3 1 0
E 5551 1 1 5 6 0
E 6601 3 0 6 3 0
E 6602 3 0 6 3 0
E 0000 1 1 6 3 1
E 2201 3 0 2 5 0
E 2202 3 1 2 5 0
S 0005 0001

// File: files.f
+incdir+src
src/axis_pkg.sv
src/tap_pkg.sv
src/axis_skid_buffer.sv
src/axis_tap.sv
src/tap_frame_counter.sv
src/tap_monitor_top.sv
sim/tap_monitor_asserts.sv
sim/tb_tap_monitor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the tap monitor testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_tap_monitor -f files.f \
    && ./obj_dir/Vtb_tap_monitor | tee sim.log \
    || { echo "build or run of the simulation failed"; exit 1; }

grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sim/tb_tap_monitor.sv
//**********************************************************************
// trace-driven testbench for the link monitor; replays per-cycle link
// and monitor stimulus, then scores the monitor beats and frame counts
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "tap_macros.svh"

module tb_tap_monitor;

    localparam int clk_period  = 20;
    localparam int max_records = 256;

    logic                 clk;
    logic                 rst;
    axis_pkg::axis_beat_t s_beat;
    logic                 s_valid;
    logic                 s_ready;
    axis_pkg::axis_beat_t m_beat;
    logic                 m_valid;
    logic                 m_ready;
    axis_pkg::axis_beat_t mon_beat;
    logic                 mon_valid;
    logic                 mon_ready;
    tap_pkg::tap_stats_t  stats;

    // per-cycle stimulus and the expected monitor stream
    axis_pkg::axis_beat_t cyc_beat [max_records];
    logic                 cyc_valid [max_records];
    logic                 cyc_m_ready [max_records];
    logic                 cyc_mon_ready [max_records];
    axis_pkg::axis_beat_t exp_beat [max_records];
    int                   num_cycles;
    int                   num_expected;
    int                   next_expected;
    int                   exp_frames;
    int                   exp_bad;
    int                   derived_frames;
    int                   derived_bad;
    int                   value_errors;
    int                   other_errors;

    always #(clk_period / 2) clk = ~clk;

    tap_monitor_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .m_beat    (m_beat),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .mon_beat  (mon_beat),
        .mon_valid (mon_valid),
        .mon_ready (mon_ready),
        .stats     (stats)
    );

    function automatic axis_pkg::axis_beat_t make_beat(
        input logic [31:0] data, keep, last, id, dest, user
    );
        axis_pkg::axis_beat_t beat;
        beat.data = data[`TAP_DATA_WIDTH-1:0];
        beat.keep = keep[`TAP_KEEP_WIDTH-1:0];
        beat.last = last[0];
        beat.id   = id[`TAP_ID_WIDTH-1:0];
        beat.dest = dest[`TAP_DEST_WIDTH-1:0];
        beat.user = user[`TAP_USER_WIDTH-1:0];
        return beat;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic report_counts;
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    endtask

    task automatic read_trace;
        int               fd;
        int               n;
        logic [7:0]       kind;
        logic [8*120-1:0] line;
        logic [31:0]      valid, data, keep, last, id;
        logic [31:0]      dest, user, link_rdy, mon_rdy;
        fd = $fopen("sim/tap_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file sim/tap_trace.txt");
            other_errors++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    n = $fgets(line, fd);
                end else if (kind == "C") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", valid, data, keep, last,
                                id, dest, user, link_rdy, mon_rdy);
                    if (n != 9) begin
                        $display("incomplete cycle record in the trace file");
                        other_errors++;
                    end
                    cyc_beat[num_cycles]      = make_beat(data, keep, last, id, dest, user);
                    cyc_valid[num_cycles]     = valid[0];
                    cyc_m_ready[num_cycles]   = link_rdy[0];
                    cyc_mon_ready[num_cycles] = mon_rdy[0];
                    num_cycles++;
                end else if (kind == "E") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h", data, keep, last, id, dest, user);
                    if (n != 6) begin
                        $display("incomplete expected beat record in the trace file");
                        other_errors++;
                    end
                    exp_beat[num_expected] = make_beat(data, keep, last, id, dest, user);
                    num_expected++;
                    // totals implied by the expected stream itself
                    if (last[0]) begin
                        derived_frames++;
                        if ((user & `TAP_BAD_FRAME_MASK) ==
                            (`TAP_BAD_FRAME_VALUE & `TAP_BAD_FRAME_MASK)) begin
                            derived_bad++;
                        end
                    end
                end else if (kind == "S") begin
                    n = $fscanf(fd, "%h %h", exp_frames, exp_bad);
                    if (n != 2) begin
                        $display("incomplete statistics record in the trace file");
                        other_errors++;
                    end
                end else begin
                    $display("unknown record kind in the trace file");
                    other_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // link path and monitor port, sampled mid-cycle
    always @(negedge clk) begin
        check_value("m_beat", 32'(s_beat), 32'(m_beat));
        check_value("m_valid", 32'(s_valid), 32'(m_valid));
        check_value("s_ready", 32'(m_ready), 32'(s_ready));
        if (!rst && mon_valid && mon_ready) begin
            assert (next_expected < num_expected) else begin
                $display("monitor port accepted a beat after the expected stream ended");
                other_errors++;
            end
            if (next_expected < num_expected) begin
                check_value("mon_beat.data", 32'(exp_beat[next_expected].data), 32'(mon_beat.data));
                check_value("mon_beat.keep", 32'(exp_beat[next_expected].keep), 32'(mon_beat.keep));
                check_value("mon_beat.last", 32'(exp_beat[next_expected].last), 32'(mon_beat.last));
                check_value("mon_beat.id", 32'(exp_beat[next_expected].id), 32'(mon_beat.id));
                check_value("mon_beat.dest", 32'(exp_beat[next_expected].dest), 32'(mon_beat.dest));
                check_value("mon_beat.user", 32'(exp_beat[next_expected].user), 32'(mon_beat.user));
                next_expected++;
            end
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        s_beat    = '0;
        s_valid   = 1'b0;
        m_ready   = 1'b0;
        mon_ready = 1'b0;
        read_trace();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_cycles; i++) begin
            s_beat    <= cyc_beat[i];
            s_valid   <= cyc_valid[i];
            m_ready   <= cyc_m_ready[i];
            mon_ready <= cyc_mon_ready[i];
            @(posedge clk);
        end
        // quiet link, open monitor until the output stage is empty
        s_beat    <= '0;
        s_valid   <= 1'b0;
        m_ready   <= 1'b1;
        mon_ready <= 1'b1;
        @(negedge clk);
        while (mon_valid) begin
            @(negedge clk);
        end
        assert (next_expected == num_expected) else begin
            $display("%0d expected monitor beats never appeared", num_expected - next_expected);
            other_errors++;
        end
        check_value("stats.frame_count", exp_frames, 32'(stats.frame_count));
        check_value("stats.bad_count", exp_bad, 32'(stats.bad_count));
        check_value("stats.frame_count", derived_frames, 32'(stats.frame_count));
        check_value("stats.bad_count", derived_bad, 32'(stats.bad_count));
        // protocol checks of the bound checker
        other_errors += u_dut.u_asserts.failure_count;
        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit scaled to the trace length
    initial begin
        #1;
        #((num_cycles + 50) * clk_period);
        $display("watchdog expired before the trace finished");
        other_errors += u_dut.u_asserts.failure_count;
        report_counts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tap_monitor_asserts.sv
//**********************************************************************
// concurrent checks on the monitor port and the tap FSM, bound into
// the monitor top level
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tap_monitor_asserts (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire axis_pkg::axis_beat_t mon_beat,
    input wire logic                 mon_valid,
    input wire logic                 mon_ready,
    input wire tap_pkg::tap_state_e  tap_state,
    input wire logic                 int_valid,
    input wire logic                 int_ready
);

    // number of failed checks so far
    int failure_count = 0;

    // stalled monitor beat stays put until taken
    mon_hold: assert property (@(posedge clk) disable iff (rst)
        mon_valid && !mon_ready |=> mon_valid && $stable(mon_beat))
        else begin
            $error("monitor beat changed or vanished while stalled");
            failure_count++;
        end

    // output stage leaves reset empty
    reset_empty: assert property (@(posedge clk) rst |=> !mon_valid)
        else begin
            $error("mon_valid high in the cycle after reset");
            failure_count++;
        end

    // truncate is only left through the marker handshake
    marker_sent: assert property (@(posedge clk) disable iff (rst)
        tap_state == tap_pkg::TAP_TRUNCATE && !(int_valid && int_ready)
        |=> tap_state == tap_pkg::TAP_TRUNCATE)
        else begin
            $error("tap left the truncate state without sending the marker beat");
            failure_count++;
        end

endmodule

bind tap_monitor_top tap_monitor_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .mon_beat  (mon_beat),
    .mon_valid (mon_valid),
    .mon_ready (mon_ready),
    .tap_state (u_tap.state),
    .int_valid (u_tap.int_valid),
    .int_ready (u_tap.int_ready)
);

`default_nettype wire

// File: src/tap_monitor_top.sv
//********************************************************************
// link monitor top; the link passes straight through while the tap
// feeds a separate monitor stream and its frame counters
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tap_monitor_top (
    input  wire logic                clk,
    input  wire logic                rst,
    // link source side
    input  wire axis_pkg::axis_beat_t s_beat,
    input  wire logic                s_valid,
    output logic                     s_ready,
    // link sink side
    output axis_pkg::axis_beat_t     m_beat,
    output logic                     m_valid,
    input  wire logic                m_ready,
    // monitor stream
    output axis_pkg::axis_beat_t     mon_beat,
    output logic                     mon_valid,
    input  wire logic                mon_ready,
    output tap_pkg::tap_stats_t      stats
);

    // zero-latency link path, never stalled by the monitor
    assign m_beat  = s_beat;
    assign m_valid = s_valid;
    assign s_ready = m_ready;

    axis_tap u_tap (
        .clk       (clk),
        .rst       (rst),
        .tap_beat  (s_beat),
        .tap_valid (s_valid),
        .tap_ready (m_ready),
        .mon_beat  (mon_beat),
        .mon_valid (mon_valid),
        .mon_ready (mon_ready)
    );

    tap_frame_counter u_counter (
        .clk       (clk),
        .rst       (rst),
        .mon_beat  (mon_beat),
        .mon_valid (mon_valid),
        .mon_ready (mon_ready),
        .stats     (stats)
    );

endmodule

`default_nettype wire

// File: src/tap_frame_counter.sv
//********************************************************************
// frame and bad-frame counters fed by the accepted monitor beats
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "tap_macros.svh"

module tap_frame_counter (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire axis_pkg::axis_beat_t mon_beat,
    input  wire logic                mon_valid,
    input  wire logic                mon_ready,
    output tap_pkg::tap_stats_t      stats
);

    localparam logic [`TAP_USER_WIDTH-1:0] bad_value = `TAP_USER_WIDTH'(`TAP_BAD_FRAME_VALUE);
    localparam logic [`TAP_USER_WIDTH-1:0] bad_mask  = `TAP_USER_WIDTH'(`TAP_BAD_FRAME_MASK);

    logic frame_end;
    logic frame_bad;

    // end of frame accepted by the monitor sink
    assign frame_end = mon_valid && mon_ready && mon_beat.last;
    assign frame_bad = (mon_beat.user & bad_mask) == (bad_value & bad_mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            stats.frame_count <= '0;
            stats.bad_count   <= '0;
        end else if (frame_end) begin
            stats.frame_count <= stats.frame_count + 16'd1;
            if (frame_bad) begin
                stats.bad_count <= stats.bad_count + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/axis_tap.sv
//********************************************************************
// frame-aware copy of an observed link onto a monitor stream; frames
// the monitor cannot keep up with are cut short with a marker beat
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "tap_macros.svh"

module axis_tap (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire axis_pkg::axis_beat_t tap_beat,
    input  wire logic                tap_valid,
    input  wire logic                tap_ready,
    output axis_pkg::axis_beat_t     mon_beat,
    output logic                     mon_valid,
    input  wire logic                mon_ready
);

    localparam logic [`TAP_USER_WIDTH-1:0] bad_value = `TAP_USER_WIDTH'(`TAP_BAD_FRAME_VALUE);
    localparam logic [`TAP_USER_WIDTH-1:0] bad_mask  = `TAP_USER_WIDTH'(`TAP_BAD_FRAME_MASK);

    tap_pkg::tap_state_e  state;
    tap_pkg::tap_state_e  state_next;
    logic                 frame;
    logic                 frame_next;
    logic                 link_xfer;
    logic                 store_last;

    // sideband of the first beat that could not be copied
    logic [`TAP_ID_WIDTH-1:0]   last_id;
    logic [`TAP_DEST_WIDTH-1:0] last_dest;
    logic [`TAP_USER_WIDTH-1:0] last_user;

    axis_pkg::axis_beat_t int_beat;
    logic                 int_valid;
    logic                 int_ready;

    assign link_xfer = tap_valid && tap_ready;

    always_comb begin
        state_next = state;
        frame_next = frame;
        store_last = 1'b0;
        int_beat   = '0;
        int_valid  = 1'b0;

        if (link_xfer) begin
            frame_next = !tap_beat.last;
        end

        case (state)
            tap_pkg::TAP_IDLE: begin
                if (link_xfer) begin
                    if (int_ready) begin
                        int_beat  = tap_beat;
                        int_valid = 1'b1;
                        if (!tap_beat.last) begin
                            state_next = tap_pkg::TAP_TRANSFER;
                        end
                    end else if (!tap_beat.last) begin
                        // a single-beat frame is already over, stay idle
                        state_next = tap_pkg::TAP_WAIT;
                    end
                end
            end
            tap_pkg::TAP_TRANSFER: begin
                if (link_xfer) begin
                    if (int_ready) begin
                        int_beat  = tap_beat;
                        int_valid = 1'b1;
                        if (tap_beat.last) begin
                            state_next = tap_pkg::TAP_IDLE;
                        end
                    end else begin
                        store_last = 1'b1;
                        state_next = tap_pkg::TAP_TRUNCATE;
                    end
                end
            end
            tap_pkg::TAP_TRUNCATE: begin
                if (int_ready) begin
                    int_beat.data = '0;
                    int_beat.keep = `TAP_KEEP_WIDTH'(1);
                    int_beat.last = 1'b1;
                    int_beat.id   = last_id;
                    int_beat.dest = last_dest;
                    int_beat.user = (last_user & ~bad_mask) | (bad_value & bad_mask);
                    int_valid     = 1'b1;
                    // link frame may have ended while the marker was pending
                    if (frame_next) begin
                        state_next = tap_pkg::TAP_WAIT;
                    end else begin
                        state_next = tap_pkg::TAP_IDLE;
                    end
                end
            end
            tap_pkg::TAP_WAIT: begin
                if (link_xfer && tap_beat.last) begin
                    state_next = tap_pkg::TAP_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= tap_pkg::TAP_IDLE;
            frame <= 1'b0;
        end else begin
            state <= state_next;
            frame <= frame_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_id   <= tap_beat.id;
            last_dest <= tap_beat.dest;
            last_user <= tap_beat.user;
        end
    end

    axis_skid_buffer u_skid (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (int_beat),
        .in_valid  (int_valid),
        .int_ready (int_ready),
        .out_beat  (mon_beat),
        .out_valid (mon_valid),
        .out_ready (mon_ready)
    );

endmodule

`default_nettype wire

// File: src/axis_skid_buffer.sv
//********************************************************************
// registered output stage with one spare register; the source sees a
// registered ready and must only present beats while it is high
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire axis_pkg::axis_beat_t in_beat,
    input  wire logic                in_valid,
    output logic                     int_ready,
    output axis_pkg::axis_beat_t     out_beat,
    output logic                     out_valid,
    input  wire logic                out_ready
);

    axis_pkg::axis_beat_t out_reg;
    axis_pkg::axis_beat_t temp_reg;
    logic                 out_valid_reg;
    logic                 out_valid_next;
    logic                 temp_valid_reg;
    logic                 temp_valid_next;
    logic                 early_ready;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // ready next cycle if the sink takes data or nothing is buffered
    assign early_ready = out_ready || (!temp_valid_reg && !out_valid_reg);

    assign out_beat  = out_reg;
    assign out_valid = out_valid_reg;

    always_comb begin
        out_valid_next    = out_valid_reg;
        temp_valid_next   = temp_valid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (int_ready) begin
            if (out_ready || !out_valid_reg) begin
                // output register free or leaving this cycle
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // drain the spare register behind an accepted output
            out_valid_next    = temp_valid_reg;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
            int_ready      <= 1'b0;
        end else begin
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            int_ready      <= early_ready;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= in_beat;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end

        if (store_in_to_temp) begin
            temp_reg <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: src/tap_pkg.sv
//********************************************************************
// tap FSM states and the frame statistics record of the monitor
//********************************************************************
`default_nettype none

package tap_pkg;

    // frame tracking states of the tap
    typedef enum logic [1:0] {
        TAP_IDLE     = 2'd0,
        TAP_TRANSFER = 2'd1,
        TAP_TRUNCATE = 2'd2,
        TAP_WAIT     = 2'd3
    } tap_state_e;

    // counts seen at the monitor port, both wrap at 16 bits
    typedef struct packed {
        logic [15:0] frame_count;
        logic [15:0] bad_count;
    } tap_stats_t;

endpackage

`default_nettype wire

// File: src/axis_pkg.sv
//********************************************************************
// stream beat type shared by the link, the tap and the monitor port
//********************************************************************
`default_nettype none

`include "tap_macros.svh"

package axis_pkg;

    // one AXI4-Stream transfer, all sideband fields always carried
    typedef struct packed {
        logic [`TAP_DATA_WIDTH-1:0] data;
        logic [`TAP_KEEP_WIDTH-1:0] keep;
        logic                       last;
        logic [`TAP_ID_WIDTH-1:0]   id;
        logic [`TAP_DEST_WIDTH-1:0] dest;
        logic [`TAP_USER_WIDTH-1:0] user;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: src/tap_macros.svh
//********************************************************************
// field widths of the monitored stream and the bad-frame marker bits,
// included by every file that sizes a beat field or checks the marker
//********************************************************************
`ifndef TAP_MACROS_SVH
`define TAP_MACROS_SVH

// stream beat field widths
`define TAP_DATA_WIDTH 16
`define TAP_KEEP_WIDTH 2
`define TAP_ID_WIDTH   4
`define TAP_DEST_WIDTH 4
`define TAP_USER_WIDTH 1

// user bits written into a truncation marker
`define TAP_BAD_FRAME_VALUE 1

// user bits that the marker value overwrites
`define TAP_BAD_FRAME_MASK  1

`endif
